/* build.f */
+incdir+hdl
hdl/beat_pkg.sv
hdl/pred_pkg.sv
hdl/beat_assembler.sv
hdl/beat_fifo.sv
hdl/lane_popcount.sv
hdl/predicate_counter.sv
hdl/scan_top.sv
tb/scan_clock_gen.sv
tb/scan_assert.sv
tb/scan_tb.sv

/* tb/scan_tb.sv */
`include "scan_params.svh"

module scan_tb
  import beat_pkg::*;
  import pred_pkg::*;
();

  localparam int NUM_STREAMS = 10;
  localparam int MAX_BEATS   = `SCAN_FIFO_DEPTH + 1;
  localparam int CYCLE_LIMIT = NUM_STREAMS * (MAX_BEATS * `SCAN_LANES + 40);
  localparam int DRIVE_DELAY = 5;

  logic                     clk;
  logic                     rst_n;
  logic                     word_valid;
  logic [`SCAN_LANE_W-1:0]  word_data;
  logic                     word_last;
  logic                     hold;
  logic                     clr;
  pred_t                    pred;
  logic [`SCAN_LANE_W-1:0]  operand;
  logic                     buf_full;
  logic                     overflow;
  logic [`SCAN_COUNT_W-1:0] result_count;
  logic                     done;

  logic [31:0] rng_state;
  int          mismatches    = 0;
  int          cycle_count   = 0;
  int          assert_errors = 0;

  scan_clock_gen i_clock (
    .clk   (clk),
    .rst_n (rst_n)
  );

  scan_top i_dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .word_valid   (word_valid),
    .word_data    (word_data),
    .word_last    (word_last),
    .hold         (hold),
    .clr          (clr),
    .pred         (pred),
    .operand      (operand),
    .buf_full     (buf_full),
    .overflow     (overflow),
    .result_count (result_count),
    .done         (done)
  );

  bind scan_top scan_assert i_assert (
    .clk          (clk),
    .rst_n        (rst_n),
    .word_valid   (word_valid),
    .word_data    (word_data),
    .clr          (clr),
    .pred         (pred),
    .operand      (operand),
    .buf_full     (buf_full),
    .overflow     (overflow),
    .result_count (result_count),
    .done         (done),
    .scan_valid   (scan_valid),
    .scan_last    (scan_last)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Unsigned comparison of one lane with the operand.
  function automatic bit lane_matches(input logic [31:0] value, input pred_t code,
                                      input logic [31:0] op);
    case (code)
      PRED_EQ: return value == op;
      PRED_NE: return value != op;
      PRED_LT: return value < op;
      PRED_LE: return value <= op;
      PRED_GT: return value > op;
      PRED_GE: return value >= op;
      default: return 1'b0;
    endcase
  endfunction

  task automatic tick();
    @(posedge clk);
    #DRIVE_DELAY;
  endtask

  // About half the words fall in 0..15 so equal outcomes show up.
  task automatic draw_word(output logic [31:0] value);
    rng_state = xorshift32(rng_state);
    value = rng_state[0] ? {28'd0, rng_state[7:4]} : rng_state;
  endtask

  task automatic send_beat(input bit last, input bit counted, inout int hits);
    logic [31:0] value;
    lane_idx_t   lane;
    for (int i = 0; i < `SCAN_LANES; i++) begin
      lane = lane_idx_t'(i);
      draw_word(value);
      word_valid = 1'b1;
      word_data  = value;
      word_last  = last && (lane == '1);
      if (counted && lane_matches(value, pred, operand)) begin
        hits++;
      end
      tick();
    end
    word_valid = 1'b0;
    word_last  = 1'b0;
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      mismatches++;
      $display("CHECK FAILED %s expected %0d actual %0d", name, expected, actual);
    end
  endtask

  task automatic wait_done();
    while (done !== 1'b1) begin
      tick();
    end
  endtask

  task automatic clear_result(input string name);
    // Done must stay up on its own for a few cycles.
    repeat (3) tick();
    clr = 1'b1;
    tick();
    clr = 1'b0;
    check_value({name, "_clr_count"}, 32'd0, result_count);
    check_value({name, "_clr_done"}, 32'd0, {31'd0, done});
  endtask

  task automatic run_stream(input string name, input pred_t code, input logic [31:0] op,
                            input int beats);
    int expected;
    expected = 0;
    pred     = code;
    operand  = op;
    for (int b = 0; b < beats; b++) begin
      send_beat(b == beats - 1, 1'b1, expected);
    end
    wait_done();
    check_value(name, expected, result_count);
    clear_result(name);
  endtask

  // Fills the buffer under hold and may add one beat that must be dropped.
  task automatic run_held_stream(input string name, input bit extra_beat);
    int expected;
    int waited;
    expected = 0;
    pred     = PRED_LT;
    operand  = 32'd10;
    hold     = 1'b1;
    for (int b = 0; b < `SCAN_FIFO_DEPTH; b++) begin
      send_beat(b == `SCAN_FIFO_DEPTH - 1, 1'b1, expected);
    end
    waited = 0;
    while (buf_full !== 1'b1 && waited < 4) begin
      tick();
      waited++;
    end
    if (buf_full !== 1'b1) begin
      mismatches++;
      $display("%s: buffer never reported full after %0d held beats", name, `SCAN_FIFO_DEPTH);
    end
    if (extra_beat) begin
      send_beat(1'b0, 1'b0, expected);
      waited = 0;
      while (overflow !== 1'b1 && waited < 4) begin
        tick();
        waited++;
      end
      if (overflow !== 1'b1) begin
        mismatches++;
        $display("%s: beat written into a full buffer did not raise overflow", name);
      end
    end else begin
      check_value({name, "_overflow"}, 32'd0, {31'd0, overflow});
    end
    hold = 1'b0;
    wait_done();
    check_value(name, expected, result_count);
    clear_result(name);
  endtask

  // Run limit.
  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > CYCLE_LIMIT) begin
      $display("timeout: run did not finish within %0d cycles, %0d value errors so far",
               CYCLE_LIMIT, mismatches);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  initial begin
    word_valid = 1'b0;
    word_data  = '0;
    word_last  = 1'b0;
    hold       = 1'b0;
    clr        = 1'b0;
    pred       = PRED_EQ;
    operand    = '0;
    rng_state  = 32'h5d69a189;

    @(posedge rst_n);
    tick();

    run_stream("pred_eq", PRED_EQ, 32'd7, 2);
    run_stream("pred_ne", PRED_NE, 32'd3, 2);
    run_stream("pred_lt", PRED_LT, 32'd9, 2);
    run_stream("pred_le", PRED_LE, 32'h8000_0000, 2);
    run_stream("pred_gt", PRED_GT, 32'd5, 2);
    run_stream("pred_ge", PRED_GE, 32'hc000_0000, 2);
    // Code 7 has no comparison.
    run_stream("pred_code7", pred_t'(3'd7), 32'd4, 2);
    run_stream("multi_beat", PRED_LE, 32'd8, 5);
    run_held_stream("hold_full", 1'b0);
    run_held_stream("overflow_drop", 1'b1);

    repeat (4) tick();
    assert_errors = i_dut.i_assert.fail_count;
    $display("value errors: %0d, assertion errors: %0d", mismatches, assert_errors);
    if (mismatches == 0 && assert_errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

/* tb/scan_assert.sv */
`include "scan_params.svh"

module scan_assert
  import beat_pkg::*;
  import pred_pkg::*;
(
  input logic                     clk,
  input logic                     rst_n,
  input logic                     word_valid,
  input logic [`SCAN_LANE_W-1:0]  word_data,
  input logic                     clr,
  input pred_t                    pred,
  input logic [`SCAN_LANE_W-1:0]  operand,
  input logic                     buf_full,
  input logic                     overflow,
  input logic [`SCAN_COUNT_W-1:0] result_count,
  input logic                     done,
  input logic                     scan_valid,
  input logic                     scan_last
);

  int fail_count = 0;

  lane_idx_t                lane_pos;
  logic [4:0]               beat_hits;
  logic [4:0]               pend_hits;
  logic                     pend_valid;
  logic                     word_hit;
  logic [`SCAN_COUNT_W-1:0] pend_add;
  logic [`SCAN_COUNT_W-1:0] model_total;

  // Unsigned predicate rule, unknown codes never hit.
  function automatic logic pred_hit(input logic [31:0] value, input pred_t code,
                                    input logic [31:0] op);
    case (code)
      PRED_EQ: return value == op;
      PRED_NE: return value != op;
      PRED_LT: return value < op;
      PRED_LE: return value <= op;
      PRED_GT: return value > op;
      PRED_GE: return value >= op;
      default: return 1'b0;
    endcase
  endfunction

  assign word_hit = word_valid && pred_hit(word_data, pred, operand);
  // A finished beat that meets a full buffer is lost.
  assign pend_add = (pend_valid && !buf_full) ? {{(`SCAN_COUNT_W-5){1'b0}}, pend_hits} : '0;

  // Shadow of the expected total, built from host words only.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      lane_pos    <= '0;
      beat_hits   <= '0;
      pend_hits   <= '0;
      pend_valid  <= 1'b0;
      model_total <= '0;
    end else begin
      pend_valid <= word_valid && (lane_pos == '1);
      if (word_valid) begin
        lane_pos <= lane_pos + 1'b1;
        if (lane_pos == '1) begin
          beat_hits <= '0;
          pend_hits <= beat_hits + {4'd0, word_hit};
        end else begin
          beat_hits <= beat_hits + {4'd0, word_hit};
        end
      end
      model_total <= (clr ? '0 : model_total) + pend_add;
    end
  end

  a_reset_idle: assert property (@(posedge clk)
    $rose(rst_n) |-> !buf_full && !overflow && !done && (result_count == '0))
    else begin
      fail_count++;
      $error("outputs are not idle right after reset");
    end

  a_done_total: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(done) |-> (result_count == model_total))
    else begin
      fail_count++;
      $error("result_count %0d differs from shadow total %0d at done",
             result_count, model_total);
    end

  // Seven cycles from the last beat leaving the buffer.
  a_done_latency: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(done) |-> $past(scan_valid && scan_last, 7))
    else begin
      fail_count++;
      $error("done rose without the last beat seven cycles earlier");
    end

  a_done_holds: assert property (@(posedge clk) disable iff (!rst_n)
    done && !clr |=> done)
    else begin
      fail_count++;
      $error("done dropped without clr");
    end

  a_clr_zeroes: assert property (@(posedge clk) disable iff (!rst_n)
    clr |=> (result_count == '0) && !done)
    else begin
      fail_count++;
      $error("clr did not zero result_count and done");
    end

  a_overflow_cause: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(overflow) |-> $past(buf_full))
    else begin
      fail_count++;
      $error("overflow rose while the buffer was not full");
    end

endmodule

/* tb/scan_clock_gen.sv */
module scan_clock_gen (
  output logic clk,
  output logic rst_n
);

  // Period of 40.
  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Reset low for three rising edges, released just after an edge.
  initial begin
    rst_n = 1'b0;
    repeat (3) @(posedge clk);
    #5;
    rst_n = 1'b1;
  end

endmodule

/* hdl/scan_top.sv */
`include "scan_params.svh"

module scan_top
  import beat_pkg::*;
  import pred_pkg::*;
(
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     word_valid,
  input  logic [`SCAN_LANE_W-1:0]  word_data,
  input  logic                     word_last,
  input  logic                     hold,
  input  logic                     clr,
  input  pred_t                    pred,
  input  logic [`SCAN_LANE_W-1:0]  operand,
  output logic                     buf_full,
  output logic                     overflow,
  output logic [`SCAN_COUNT_W-1:0] result_count,
  output logic                     done
);

  // Producer to buffer.
  logic  beat_valid;
  beat_t beat;
  logic  beat_last;

  // Buffer to consumer.
  logic  scan_valid;
  beat_t scan_beat;
  logic  scan_last;

  beat_assembler i_producer (
    .clk        (clk),
    .rst_n      (rst_n),
    .word_valid (word_valid),
    .word_data  (word_data),
    .word_last  (word_last),
    .beat_valid (beat_valid),
    .beat       (beat),
    .beat_last  (beat_last)
  );

  beat_fifo i_buffer (
    .clk      (clk),
    .rst_n    (rst_n),
    .wr_valid (beat_valid),
    .wr_beat  (beat),
    .wr_last  (beat_last),
    .hold     (hold),
    .full     (buf_full),
    .overflow (overflow),
    .rd_valid (scan_valid),
    .rd_beat  (scan_beat),
    .rd_last  (scan_last)
  );

  predicate_counter i_consumer (
    .clk          (clk),
    .rst_n        (rst_n),
    .scan_valid   (scan_valid),
    .scan_beat    (scan_beat),
    .scan_last    (scan_last),
    .pred         (pred),
    .operand      (operand),
    .clr          (clr),
    .result_count (result_count),
    .done         (done)
  );

endmodule

/* hdl/predicate_counter.sv */
`include "scan_params.svh"

module predicate_counter
  import beat_pkg::*;
  import pred_pkg::*;
(
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     scan_valid,
  input  beat_t                    scan_beat,
  input  logic                     scan_last,
  input  pred_t                    pred,
  input  logic [`SCAN_LANE_W-1:0]  operand,
  input  logic                     clr,
  output logic [`SCAN_COUNT_W-1:0] result_count,
  output logic                     done
);

  localparam int LAST_DLY = 5;

  logic [`SCAN_LANES-1:0] lt_w;
  logic [`SCAN_LANES-1:0] eq_w;

  // All six outcomes per lane, registered.
  logic [`SCAN_LANES-1:0] eq_q;
  logic [`SCAN_LANES-1:0] ne_q;
  logic [`SCAN_LANES-1:0] lt_q;
  logic [`SCAN_LANES-1:0] le_q;
  logic [`SCAN_LANES-1:0] gt_q;
  logic [`SCAN_LANES-1:0] ge_q;

  pred_t                  pred_q;
  logic [`SCAN_LANES-1:0] match_q;
  logic                   flags_valid_q;
  logic                   match_valid_q;

  logic                   pop_valid;
  logic [4:0]             pop_count;

  logic [LAST_DLY-1:0]     last_dly;
  logic [`SCAN_COUNT_W-1:0] total;
  logic                    last_seen;
  logic                    got_count;

  // Unsigned compare of each lane against the operand.
  for (genvar i = 0; i < `SCAN_LANES; i++) begin : g_lane
    assign lt_w[i] = scan_beat.lanes[i] < operand;
    assign eq_w[i] = scan_beat.lanes[i] == operand;
  end

  // Stage t+1. Idle cycles leave all flags at zero.
  always_ff @(posedge clk) begin
    pred_q <= pred;
    if (scan_valid) begin
      eq_q <= eq_w;
      ne_q <= ~eq_w;
      lt_q <= lt_w;
      le_q <= lt_w | eq_w;
      gt_q <= ~(lt_w | eq_w);
      ge_q <= ~lt_w;
    end else begin
      eq_q <= '0;
      ne_q <= '0;
      lt_q <= '0;
      le_q <= '0;
      gt_q <= '0;
      ge_q <= '0;
    end
  end

  // Stage t+2, pick the outcome for the requested predicate.
  always_ff @(posedge clk) begin
    case (pred_q)
      PRED_EQ: match_q <= eq_q;
      PRED_NE: match_q <= ne_q;
      PRED_LT: match_q <= lt_q;
      PRED_LE: match_q <= le_q;
      PRED_GT: match_q <= gt_q;
      PRED_GE: match_q <= ge_q;
      default: match_q <= '0;
    endcase
  end

  lane_popcount i_popcount (
    .clk         (clk),
    .rst_n       (rst_n),
    .flags_valid (match_valid_q),
    .flags       (match_q),
    .count_valid (pop_valid),
    .count       (pop_count)
  );

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      flags_valid_q <= 1'b0;
      match_valid_q <= 1'b0;
      last_dly      <= '0;
      total         <= '0;
      last_seen     <= 1'b0;
      got_count     <= 1'b0;
      result_count  <= '0;
      done          <= 1'b0;
    end else begin
      flags_valid_q <= scan_valid;
      match_valid_q <= flags_valid_q;
      // Last marker, one stage behind the count at the tail.
      last_dly <= {last_dly[LAST_DLY-2:0], scan_valid & scan_last};
      // A count landing with clr survives the clear.
      total <= (clr ? '0 : total)
             + (pop_valid ? {{(`SCAN_COUNT_W-5){1'b0}}, pop_count} : '0);
      got_count <= (got_count & ~clr) | pop_valid;
      last_seen <= (last_seen & ~clr) | last_dly[LAST_DLY-1];
      result_count <= clr ? '0 : total;
      done         <= clr ? 1'b0 : (last_seen & got_count);
    end
  end

endmodule

/* hdl/lane_popcount.sv */
`include "scan_params.svh"

module lane_popcount (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   flags_valid,
  input  logic [`SCAN_LANES-1:0] flags,
  output logic                   count_valid,
  output logic [4:0]             count
);

  localparam int GROUPS = `SCAN_LANES / 4;

  logic [2:0] group_cnt [GROUPS];
  logic       stage1_valid;

  // Set bits in a nibble.
  function automatic logic [2:0] ones4(input logic [3:0] nib);
    logic [2:0] sum;
    sum = '0;
    for (int b = 0; b < 4; b++) begin
      sum = sum + {2'b00, nib[b]};
    end
    return sum;
  endfunction

  // Stage one, one count per group of four lanes.
  always_ff @(posedge clk) begin
    for (int g = 0; g < GROUPS; g++) begin
      group_cnt[g] <= ones4(flags[g*4 +: 4]);
    end
  end

  // Stage two, sum of the group counts.
  always_ff @(posedge clk) begin
    logic [4:0] total;
    total = '0;
    for (int g = 0; g < GROUPS; g++) begin
      total = total + {2'b00, group_cnt[g]};
    end
    count <= total;
  end

  // Valid follows the data through both stages.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      stage1_valid <= 1'b0;
      count_valid  <= 1'b0;
    end else begin
      stage1_valid <= flags_valid;
      count_valid  <= stage1_valid;
    end
  end

endmodule

/* hdl/beat_fifo.sv */
`include "scan_params.svh"

module beat_fifo
  import beat_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  input  logic  wr_valid,
  input  beat_t wr_beat,
  input  logic  wr_last,
  input  logic  hold,
  output logic  full,
  output logic  overflow,
  output logic  rd_valid,
  output beat_t rd_beat,
  output logic  rd_last
);

  localparam int DEPTH = `SCAN_FIFO_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int BEAT_W = `SCAN_LANES * `SCAN_LANE_W;

  logic [BEAT_W-1:0] beat_mem [DEPTH];
  logic              last_mem [DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   used;
  logic             wr_en;
  logic             rd_en;

  assign full  = (used == (PTR_W + 1)'(DEPTH));
  assign wr_en = wr_valid && !full;
  // Drains on its own; the consumer never stalls.
  assign rd_en = (used != '0) && !hold;

  // Storage.
  always_ff @(posedge clk) begin
    if (wr_en) begin
      beat_mem[wr_ptr] <= wr_beat.flat;
      last_mem[wr_ptr] <= wr_last;
    end
  end

  // Registered read port.
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_beat.flat <= beat_mem[rd_ptr];
      rd_last      <= last_mem[rd_ptr];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      used     <= '0;
      rd_valid <= 1'b0;
      overflow <= 1'b0;
    end else begin
      rd_valid <= rd_en;
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // Occupancy moves only when one side acts alone.
      if (wr_en && !rd_en) begin
        used <= used + 1'b1;
      end else if (rd_en && !wr_en) begin
        used <= used - 1'b1;
      end
      // Sticky drop flag.
      if (wr_valid && full) begin
        overflow <= 1'b1;
      end
    end
  end

endmodule

/* hdl/beat_assembler.sv */
`include "scan_params.svh"

module beat_assembler
  import beat_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    word_valid,
  input  logic [`SCAN_LANE_W-1:0] word_data,
  input  logic                    word_last,
  output logic                    beat_valid,
  output beat_t                   beat,
  output logic                    beat_last
);

  localparam lane_idx_t LAST_LANE = lane_idx_t'(`SCAN_LANES - 1);

  lane_idx_t lane_idx;
  logic      fill_last;

  // The word in flight completes the beat.
  assign fill_last = word_valid && (lane_idx == LAST_LANE);

  // Lane pointer, wraps back to lane 0 after the last lane.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      lane_idx <= '0;
    end else if (word_valid) begin
      lane_idx <= lane_idx + 1'b1;
    end
  end

  // The output beat doubles as the holding register.
  // Lanes are overwritten by the next beat only after the pulse.
  always_ff @(posedge clk) begin
    if (word_valid) begin
      beat.lanes[lane_idx] <= word_data;
    end
  end

  // One-cycle pulse when lane 15 has been written.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      beat_valid <= 1'b0;
      beat_last  <= 1'b0;
    end else begin
      beat_valid <= fill_last;
      if (fill_last) begin
        // word_last only counts on the closing word of a beat.
        beat_last <= word_last;
      end
    end
  end

endmodule

/* hdl/pred_pkg.sv */
package pred_pkg;

  // Comparison applied to every lane, unsigned.
  // Codes 6 and 7 match no lane.
  typedef enum logic [2:0] {
    PRED_EQ = 3'd0,
    PRED_NE = 3'd1,
    PRED_LT = 3'd2,
    PRED_LE = 3'd3,
    PRED_GT = 3'd4,
    PRED_GE = 3'd5
  } pred_t;

endpackage

/* hdl/beat_pkg.sv */
`include "scan_params.svh"

package beat_pkg;

  // One beat is stored flat in the buffer.
  // Producer and consumer see it as lanes, lane 0 in the low bits.
  typedef union packed {
    logic [`SCAN_LANES*`SCAN_LANE_W-1:0]   flat;
    logic [`SCAN_LANES-1:0][`SCAN_LANE_W-1:0] lanes;
  } beat_t;

  // Position of a lane inside a beat.
  typedef logic [$clog2(`SCAN_LANES)-1:0] lane_idx_t;

endpackage

/* hdl/scan_params.svh */
`ifndef SCAN_PARAMS_SVH
`define SCAN_PARAMS_SVH

// Lanes packed into one beat.
`define SCAN_LANES 16

// Width of one lane and of one host word.
`define SCAN_LANE_W 32

// Beats held by the buffer, a power of two.
`define SCAN_FIFO_DEPTH 8

// Width of the running match total.
`define SCAN_COUNT_W 32

`endif
